// File: multiPortRam.f
src/multiPortRamPkg.sv
src/dualPortBank.sv
src/xorLiveValueTable.sv
src/readPortStage.sv
src/multiPortRam.sv
sim/multiPortRamChecker.sv
sim/multiPortRamTb.sv

// File: Bender.yml
package:
  name: multi_port_ram

sources:
  # RTL in compile order
  - src/multiPortRamPkg.sv
  - src/dualPortBank.sv
  - src/xorLiveValueTable.sv
  - src/readPortStage.sv
  - src/multiPortRam.sv

  # Testbench
  - target: simulation
    files:
      - sim/multiPortRamChecker.sv
      - sim/multiPortRamTb.sv

// File: sim/multiPortRamTb.sv
// Testbench for the multi-port RAM.
// Builds a table of stimulus rows, one row per clock cycle, and drives
// it into the DUT a short delay after each rising edge. The checker
// module models the memory and compares every read response.
// A cycle counter stops the run if the table never finishes.

`timescale 1ns/1ns

module multiPortRamTb;

    import multiPortRamPkg::*;

    localparam int EntryNum = DefaultEntryNum;
    localparam int DataWidth = DefaultDataWidth;
    localparam int WriteNum = DefaultWriteNum;
    localparam int ReadNum = DefaultReadNum;
    localparam int AddrWidth = $clog2(EntryNum);
    localparam int ResetCycles = 4;
    localparam int RowMax = 40;

    logic                 clk;
    logic                 arstN;
    logic                 we[WriteNum];
    logic [AddrWidth-1:0] wa[WriteNum];
    logic [DataWidth-1:0] wv[WriteNum];
    logic [AddrWidth-1:0] ra[ReadNum];
    logic                 rdReq[ReadNum];
    logic [DataWidth-1:0] rv[ReadNum];
    logic                 rdValid[ReadNum];

    int errorCount;
    int checkCount;
    int seed;
    int cycleCount = 0;
    int cycleLimit = 0;
    logic tableReady = 1'b0;

    // Stimulus table, one entry per cycle
    logic                 tWe[RowMax][WriteNum];
    logic [AddrWidth-1:0] tWa[RowMax][WriteNum];
    logic [DataWidth-1:0] tWv[RowMax][WriteNum];
    logic [AddrWidth-1:0] tRa[RowMax][ReadNum];
    logic                 tReq[RowMax][ReadNum];
    int                   rowCount = 0;

    multiPortRam #(
        .EntryNum (EntryNum),
        .DataWidth(DataWidth),
        .WriteNum (WriteNum),
        .ReadNum  (ReadNum)
    ) dut0 (
        .clk    (clk),
        .arstN  (arstN),
        .we     (we),
        .wa     (wa),
        .wv     (wv),
        .ra     (ra),
        .rdReq  (rdReq),
        .rv     (rv),
        .rdValid(rdValid)
    );

    multiPortRamChecker #(
        .EntryNum (EntryNum),
        .DataWidth(DataWidth),
        .WriteNum (WriteNum),
        .ReadNum  (ReadNum)
    ) chk0 (
        .clk       (clk),
        .arstN     (arstN),
        .we        (we),
        .wa        (wa),
        .wv        (wv),
        .ra        (ra),
        .rdReq     (rdReq),
        .rv        (rv),
        .rdValid   (rdValid),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [DataWidth-1:0] randWord();
        return DataWidth'($random(seed));
    endfunction

    function automatic int randBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic openRow();
        for (int w = 0; w < WriteNum; w++) begin
            tWe[rowCount][w] = 1'b0;
            tWa[rowCount][w] = '0;
            tWv[rowCount][w] = '0;
        end
        for (int r = 0; r < ReadNum; r++) begin
            tRa[rowCount][r] = '0;
            tReq[rowCount][r] = 1'b0;
        end
    endtask

    task automatic closeRow();
        rowCount++;
    endtask

    task automatic putWrite(int port, int addr, logic [DataWidth-1:0] data);
        tWe[rowCount][port] = 1'b1;
        tWa[rowCount][port] = AddrWidth'(addr);
        tWv[rowCount][port] = data;
    endtask

    task automatic putRead(int port, int addr);
        tRa[rowCount][port] = AddrWidth'(addr);
        tReq[rowCount][port] = 1'b1;
    endtask

    task automatic readAllPorts(int addr);
        for (int r = 0; r < ReadNum; r++) begin
            putRead(r, addr);
        end
    endtask

    task automatic buildTable();
        int a0;
        int a1;
        // Idle row after reset, no valid expected
        openRow();
        closeRow();
        // Port 0 write, then every read port fetches it, then idle again
        openRow();
        putWrite(0, 5, randWord());
        closeRow();
        openRow();
        readAllPorts(5);
        closeRow();
        openRow();
        closeRow();
        // Same entry from port 0 then port 1, later writer wins
        openRow();
        putWrite(0, 9, randWord());
        closeRow();
        openRow();
        putWrite(1, 9, randWord());
        closeRow();
        openRow();
        readAllPorts(9);
        closeRow();
        // Both write ports in one cycle, different entries
        openRow();
        putWrite(0, 12, randWord());
        putWrite(1, 20, randWord());
        closeRow();
        openRow();
        putRead(0, 12);
        putRead(1, 20);
        putRead(2, 12);
        closeRow();
        openRow();
        putRead(0, 20);
        putRead(1, 12);
        putRead(2, 20);
        closeRow();
        // Read and write of one entry in one cycle gives the old word
        openRow();
        putWrite(1, 5, randWord());
        readAllPorts(5);
        closeRow();
        openRow();
        readAllPorts(5);
        closeRow();
        // Fill 24..31, then back-to-back reads of three distinct entries
        for (int k = 0; k < 4; k++) begin
            openRow();
            putWrite(0, 24 + 2 * k, randWord());
            putWrite(1, 25 + 2 * k, randWord());
            closeRow();
        end
        for (int k = 0; k < 4; k++) begin
            openRow();
            putRead(0, 24 + k);
            putRead(1, 28 + k);
            putRead(2, 31 - k);
            closeRow();
        end
        // Random mix, write addresses kept apart within a row
        for (int k = 0; k < 10; k++) begin
            openRow();
            a0 = randBelow(EntryNum);
            a1 = (a0 + 1 + randBelow(EntryNum - 1)) % EntryNum;
            if (randBelow(2) != 0) begin
                putWrite(0, a0, randWord());
            end
            if (randBelow(2) != 0) begin
                putWrite(1, a1, randWord());
            end
            for (int r = 0; r < ReadNum; r++) begin
                if (randBelow(4) != 0) begin
                    putRead(r, randBelow(EntryNum));
                end
            end
            closeRow();
        end
        openRow();
        closeRow();
        openRow();
        closeRow();
    endtask

    task automatic applyRow(int i);
        for (int w = 0; w < WriteNum; w++) begin
            we[w] = tWe[i][w];
            wa[w] = tWa[i][w];
            wv[w] = tWv[i][w];
        end
        for (int r = 0; r < ReadNum; r++) begin
            ra[r] = tRa[i][r];
            rdReq[r] = tReq[i][r];
        end
    endtask

    task automatic driveIdle();
        for (int w = 0; w < WriteNum; w++) begin
            we[w] = 1'b0;
            wa[w] = '0;
            wv[w] = '0;
        end
        for (int r = 0; r < ReadNum; r++) begin
            ra[r] = '0;
            rdReq[r] = 1'b0;
        end
    endtask

    // Watchdog sized from the table length
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (tableReady && cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        seed = 69750;
        arstN = 1'b0;
        driveIdle();
        buildTable();
        cycleLimit = ResetCycles + rowCount + 20;
        tableReady = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #2;
        arstN = 1'b1;
        for (int i = 0; i < rowCount; i++) begin
            @(posedge clk);
            #2;
            applyRow(i);
        end
        // Let the last responses come back and be compared
        @(posedge clk);
        #2;
        driveIdle();
        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sim/multiPortRamChecker.sv
// Reference model and scoreboard for the multi-port RAM testbench.
// Watches the DUT ports, keeps its own copy of the memory and compares
// rv and rdValid one cycle after each read request.
// Exposes the number of checks and errors to the testbench top.

`timescale 1ns/1ns

module multiPortRamChecker #(
    parameter int EntryNum = multiPortRamPkg::DefaultEntryNum,
    parameter int DataWidth = multiPortRamPkg::DefaultDataWidth,
    parameter int WriteNum = multiPortRamPkg::DefaultWriteNum,
    parameter int ReadNum = multiPortRamPkg::DefaultReadNum
) (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        we[WriteNum],
    input  logic [$clog2(EntryNum)-1:0] wa[WriteNum],
    input  logic [DataWidth-1:0]        wv[WriteNum],
    input  logic [$clog2(EntryNum)-1:0] ra[ReadNum],
    input  logic                        rdReq[ReadNum],
    input  logic [DataWidth-1:0]        rv[ReadNum],
    input  logic                        rdValid[ReadNum],
    output int                          errorCount,
    output int                          checkCount
);

    // Model memory and which entries hold a defined word
    logic [DataWidth-1:0] model[EntryNum];
    logic                 known[EntryNum];

    // What each read port should show after the last edge
    logic [DataWidth-1:0] expRv[ReadNum];
    logic                 expValid[ReadNum];
    logic                 expKnown[ReadNum];
    logic                 armed;

    initial begin
        errorCount = 0;
        checkCount = 0;
        armed = 1'b0;
        for (int e = 0; e < EntryNum; e++) begin
            known[e] = 1'b0;
        end
        for (int r = 0; r < ReadNum; r++) begin
            expValid[r] = 1'b0;
            expKnown[r] = 1'b0;
        end
    end

    // Reads are taken before this edge's writes, which models read-first
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int r = 0; r < ReadNum; r++) begin
                expValid[r] = 1'b0;
            end
        end else begin
            for (int r = 0; r < ReadNum; r++) begin
                expValid[r] = rdReq[r];
                expRv[r] = model[ra[r]];
                expKnown[r] = known[ra[r]];
            end
            for (int w = 0; w < WriteNum; w++) begin
                if (we[w]) begin
                    model[wa[w]] = wv[w];
                    known[wa[w]] = 1'b1;
                end
            end
            // Checking starts with the first edge out of reset
            armed = 1'b1;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (armed) begin
            for (int r = 0; r < ReadNum; r++) begin
                checkCount++;
                if (rdValid[r] !== expValid[r]) begin
                    errorCount++;
                    $display("[ERROR] %0t ns: read port %0d rdValid is %b, expected %b",
                        $time, r, rdValid[r], expValid[r]);
                end
                // Entries never written hold no defined word
                if (expValid[r] && expKnown[r]) begin
                    checkCount++;
                    if (rv[r] !== expRv[r]) begin
                        errorCount++;
                        $display("[ERROR] %0t ns: read port %0d rv is %h, expected %h",
                            $time, r, rv[r], expRv[r]);
                    end
                end
            end
        end
    end

endmodule

// File: src/multiPortRam.sv
// Multi-port RAM with WriteNum write ports and ReadNum read ports.
// Built from replicated one-write, one-read banks plus an XOR live value
// table, so the last writer of each entry wins.
// Writes land at the clock edge. Reads are read-first and return data
// with rdValid one cycle after ra and rdReq.
// Two writes to one address in the same cycle are not supported.

`timescale 1ns/1ns

module multiPortRam #(
    parameter int EntryNum = multiPortRamPkg::DefaultEntryNum,
    parameter int DataWidth = multiPortRamPkg::DefaultDataWidth,
    parameter int WriteNum = multiPortRamPkg::DefaultWriteNum,
    parameter int ReadNum = multiPortRamPkg::DefaultReadNum
) (
    input  logic                        clk,
    input  logic                        arstN,

    // Write ports
    input  logic                        we[WriteNum],
    input  logic [$clog2(EntryNum)-1:0] wa[WriteNum],
    input  logic [DataWidth-1:0]        wv[WriteNum],

    // Read ports
    input  logic [$clog2(EntryNum)-1:0] ra[ReadNum],
    input  logic                        rdReq[ReadNum],
    output logic [DataWidth-1:0]        rv[ReadNum],
    output logic                        rdValid[ReadNum]
);

    import multiPortRamPkg::*;

    localparam int CodeWidth = selWidth(WriteNum);

    // Last writer for each read port's address
    logic [CodeWidth-1:0] liveSel[ReadNum];

    xorLiveValueTable #(
        .EntryNum(EntryNum),
        .WriteNum(WriteNum),
        .ReadNum (ReadNum)
    ) lvt0 (
        .clk    (clk),
        .we     (we),
        .wa     (wa),
        .ra     (ra),
        .liveSel(liveSel)
    );

    // One stage per read port, each with its own bank column
    for (genvar r = 0; r < ReadNum; r++) begin : gReadPort
        readPortStage #(
            .EntryNum (EntryNum),
            .DataWidth(DataWidth),
            .WriteNum (WriteNum)
        ) stage (
            .clk    (clk),
            .arstN  (arstN),
            .we     (we),
            .wa     (wa),
            .wv     (wv),
            .ra     (ra[r]),
            .rdReq  (rdReq[r]),
            .liveSel(liveSel[r]),
            .rv     (rv[r]),
            .rdValid(rdValid[r])
        );
    end

endmodule

// File: src/readPortStage.sv
// One read port of the multi-port RAM.
// Holds a column of data banks, one per write port, all read at the
// same address. The live value table's answer is registered alongside
// the bank read and then picks which bank's word goes out.
// Latency from ra/rdReq to rv/rdValid is one cycle.

`timescale 1ns/1ns

module readPortStage #(
    parameter int EntryNum = multiPortRamPkg::DefaultEntryNum,
    parameter int DataWidth = multiPortRamPkg::DefaultDataWidth,
    parameter int WriteNum = multiPortRamPkg::DefaultWriteNum
) (
    input  logic                                         clk,
    input  logic                                         arstN,

    // Every write port, fanned out to this port's banks
    input  logic                                         we[WriteNum],
    input  logic [$clog2(EntryNum)-1:0]                  wa[WriteNum],
    input  logic [DataWidth-1:0]                         wv[WriteNum],

    // Read request
    input  logic [$clog2(EntryNum)-1:0]                  ra,
    input  logic                                         rdReq,

    // Last writer of ra, straight from the table
    input  logic [multiPortRamPkg::selWidth(WriteNum)-1:0] liveSel,

    // Read response
    output logic [DataWidth-1:0]                         rv,
    output logic                                         rdValid
);

    import multiPortRamPkg::*;

    localparam int CodeWidth = selWidth(WriteNum);

    // Registered word from each write port's bank
    logic [DataWidth-1:0] bankRv[WriteNum];

    // Select lined up with the bank outputs
    logic [CodeWidth-1:0] liveSelQ;

    for (genvar j = 0; j < WriteNum; j++) begin : gBank
        dualPortBank #(
            .EntryNum (EntryNum),
            .DataWidth(DataWidth)
        ) bank (
            .clk(clk),
            .we (we[j]),
            .wa (wa[j]),
            .wv (wv[j]),
            .ra (ra),
            .rv (bankRv[j])
        );
    end

    // Table lookup happens before the edge, so it agrees with read-first banks
    always_ff @(posedge clk) begin
        liveSelQ <= liveSel;
    end

    // Valid follows the request by one cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= rdReq;
        end
    end

    // Take the word from whichever port wrote this entry last
    assign rv = bankRv[liveSelQ];

endmodule

// File: src/xorLiveValueTable.sv
// XOR-coded live value table for the multi-port RAM.
// Tracks, per entry, which write port wrote it last. Each write port
// keeps its own narrow arrays; the XOR of every port's stored code at
// one address gives back the index of the last writer.
// Writes land at the clock edge, lookups are combinational.

`timescale 1ns/1ns

module xorLiveValueTable #(
    parameter int EntryNum = multiPortRamPkg::DefaultEntryNum,
    parameter int WriteNum = multiPortRamPkg::DefaultWriteNum,
    parameter int ReadNum = multiPortRamPkg::DefaultReadNum
) (
    input  logic                                         clk,

    // Write ports, same enables and addresses as the data banks
    input  logic                                         we[WriteNum],
    input  logic [$clog2(EntryNum)-1:0]                  wa[WriteNum],

    // Lookup ports
    input  logic [$clog2(EntryNum)-1:0]                  ra[ReadNum],
    output logic [multiPortRamPkg::selWidth(WriteNum)-1:0] liveSel[ReadNum]
);

    import multiPortRamPkg::*;

    localparam int CodeWidth = selWidth(WriteNum);

    typedef logic [CodeWidth-1:0] code_t;

    // Code each write port stores this cycle
    code_t writeCode[WriteNum];

    // feedRd[j][i] is writer j's code at writer i's address
    code_t feedRd[WriteNum][WriteNum];

    // readRd[j][r] is writer j's code at read port r's address
    code_t readRd[WriteNum][ReadNum];

    for (genvar j = 0; j < WriteNum; j++) begin : gWriter

        // Feed banks let the other writers see this writer's codes
        for (genvar i = 0; i < WriteNum; i++) begin : gFeed
            if (j != i) begin : gBank
                code_t feedMem[EntryNum];

                // Feed and read copies of a column must agree from the start
                initial begin
                    for (int e = 0; e < EntryNum; e++) begin
                        feedMem[e] = '0;
                    end
                end

                always @(posedge clk) begin
                    if (we[j]) begin
                        feedMem[wa[j]] <= writeCode[j];
                    end
                end

                assign feedRd[j][i] = feedMem[wa[i]];
            end else begin : gSelf
                // A writer never reads its own column, so this term drops out
                assign feedRd[j][i] = '0;
            end
        end

        // One read bank per read port, all holding the same codes
        for (genvar r = 0; r < ReadNum; r++) begin : gRead
            code_t readMem[EntryNum];

            initial begin
                for (int e = 0; e < EntryNum; e++) begin
                    readMem[e] = '0;
                end
            end

            always @(posedge clk) begin
                if (we[j]) begin
                    readMem[wa[j]] <= writeCode[j];
                end
            end

            assign readRd[j][r] = readMem[ra[r]];
        end
    end

    always_comb begin
        // Writer i stores its index XOR the other writers' current codes.
        // Afterwards the XOR across all columns at that address equals i
        for (int i = 0; i < WriteNum; i++) begin
            writeCode[i] = code_t'(i);
            for (int j = 0; j < WriteNum; j++) begin
                writeCode[i] ^= feedRd[j][i];
            end
        end

        // Recover the last writer for every read port
        for (int r = 0; r < ReadNum; r++) begin
            liveSel[r] = '0;
            for (int j = 0; j < WriteNum; j++) begin
                liveSel[r] ^= readRd[j][r];
            end
        end
    end

endmodule

// File: src/dualPortBank.sv
// One-write, one-read memory bank in block-RAM style.
// The read is registered, so data shows up one cycle after the address.
// When read and write hit the same word at one edge, the old word is
// returned, which is what the replicated banks of the RAM rely on.

`timescale 1ns/1ns

module dualPortBank #(
    parameter int EntryNum = multiPortRamPkg::DefaultEntryNum,
    parameter int DataWidth = multiPortRamPkg::DefaultDataWidth
) (
    input  logic                        clk,

    // Write side
    input  logic                        we,
    input  logic [$clog2(EntryNum)-1:0] wa,
    input  logic [DataWidth-1:0]        wv,

    // Read side
    input  logic [$clog2(EntryNum)-1:0] ra,
    output logic [DataWidth-1:0]        rv
);

    // Storage array, no reset
    logic [DataWidth-1:0] mem[EntryNum];

    // Read-first port.
    // The read samples the array before this edge's write lands
    always_ff @(posedge clk) begin
        rv <= mem[ra];
        if (we) begin
            mem[wa] <= wv;
        end
    end

endmodule

// File: src/multiPortRamPkg.sv
// Shared sizing for the multi-port RAM.
// Holds the default geometry that the top level hands down to its
// children, plus the width helper for write-port indices.
// Modules import it in their bodies and use scoped names in headers.

package multiPortRamPkg;

    // Number of addressable words
    localparam int DefaultEntryNum = 32;

    // Bits per stored word
    localparam int DefaultDataWidth = 16;

    // Write ports, each owning one column of banks
    localparam int DefaultWriteNum = 2;

    // Read ports, each owning one bank per write port
    localparam int DefaultReadNum = 3;

    // Width of a write-port index as kept in the live value table.
    // A single write port still needs one bit so the select stays legal.
    function automatic int selWidth(input int writeNum);
        int width;
        if (writeNum > 1) begin
            width = $clog2(writeNum);
        end else begin
            width = 1;
        end
        return width;
    endfunction

endpackage
